//--- run.sh
#!/usr/bin/env bash
# build with verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert -f vlog.f --top-module tile_wrap_tb \
  -o tile_wrap_sim > build.log 2>&1 &&
./obj_dir/tile_wrap_sim +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log 2>/dev/null || cat build.log
grep -qx "Regression passed" sim.log && echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }

//--- src/event_logger.sv
`timescale 1ns/1ns

module event_logger (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  tile_pkg::src_vec_t src_i,
  input  logic               log_gnt_i,
  output logic               log_we_o,
  output tile_pkg::ev_addr_t log_addr_o,
  output tile_pkg::ev_data_t log_data_o,
  output tile_pkg::ev_addr_t wr_ptr_o
);

  tile_pkg::src_vec_t src_q;
  tile_pkg::src_vec_t rise;
  tile_pkg::src_vec_t pend_q;
  tile_pkg::src_vec_t done_mask;
  tile_pkg::src_id_t  sel_id;
  tile_pkg::tstamp_t  tstamp_q;
  tile_pkg::ev_addr_t wr_ptr_q;
  tile_pkg::ev_addr_t wr_ptr_nxt;
  logic               log_fire;

  ////////////////////
  // edge detect
  ////////////////////

  // held level yields a single edge
  assign rise = src_i & ~src_q;

  ////////////////////
  // source select
  ////////////////////

  // walk downwards so the lowest pending id wins
  always_comb begin
    sel_id = '0;
    for (int i = tile_pkg::NUM_SRC - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        sel_id = tile_pkg::src_id_t'(i);
      end
    end
  end

  assign log_fire  = log_we_o & log_gnt_i;
  assign done_mask = log_fire ? (tile_pkg::src_vec_t'(1) << sel_id) : '0;

  // ring wrap
  assign wr_ptr_nxt = (wr_ptr_q == tile_pkg::ev_addr_t'(tile_pkg::EV_DEPTH - 1)) ?
                      '0 : wr_ptr_q + 1'b1;

  ////////////////////
  // state
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q    <= '0;
      pend_q   <= '0;
      tstamp_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      src_q    <= src_i;
      // edge on an already pending source folds into it
      pend_q   <= (pend_q & ~done_mask) | rise;
      // free running, wraps silently
      tstamp_q <= tstamp_q + 1'b1;
      if (log_fire) begin
        wr_ptr_q <= wr_ptr_nxt;
      end
    end
  end

  // record is {source, time of write}
  assign log_we_o   = |pend_q;
  assign log_addr_o = wr_ptr_q;
  assign log_data_o = {sel_id, tstamp_q};
  assign wr_ptr_o   = wr_ptr_q;

endmodule

//--- src/event_sram.sv
`timescale 1ns/1ns

module event_sram (
  input  logic               clk_i,
  input  logic               we_i,
  input  logic               re_i,
  input  tile_pkg::ev_addr_t addr_i,
  input  tile_pkg::ev_data_t wdata_i,
  output tile_pkg::ev_data_t rdata_o
);

  // single port, one access per cycle
  tile_pkg::ev_data_t mem_q [tile_pkg::EV_DEPTH];
  tile_pkg::ev_data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // registered read, holds between reads
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
  input  logic               clk_i,
  input  logic               reset_l,
  input  logic               clr_we_i,
  input  tile_pkg::ev_addr_t clr_addr_i,
  input  logic               log_we_i,
  input  tile_pkg::ev_addr_t log_addr_i,
  input  tile_pkg::ev_data_t log_data_i,
  input  logic               host_req_i,
  input  tile_pkg::ev_addr_t host_addr_i,
  output logic               clr_gnt_o,
  output logic               log_gnt_o,
  output logic               mem_we_o,
  output logic               mem_re_o,
  output tile_pkg::ev_addr_t mem_addr_o,
  output tile_pkg::ev_data_t mem_wdata_o,
  output logic               host_rvalid_o
);

  logic host_gnt;
  logic rvalid_q;

  // fixed order: clear, logger, host
  assign clr_gnt_o = clr_we_i;
  assign log_gnt_o = log_we_i & ~clr_we_i;
  // host blocked in its valid cycle so a held request is not read twice
  assign host_gnt  = host_req_i & ~clr_we_i & ~log_we_i & ~rvalid_q;

  ////////////////////
  // memory port
  ////////////////////

  assign mem_we_o    = clr_gnt_o | log_gnt_o;
  assign mem_re_o    = host_gnt;
  assign mem_addr_o  = clr_gnt_o ? clr_addr_i :
                       log_gnt_o ? log_addr_i : host_addr_i;
  // sweep writes zeros
  assign mem_wdata_o = log_gnt_o ? log_data_i : '0;

  // read data shows up one cycle after the grant
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= host_gnt;
    end
  end

  assign host_rvalid_o = rvalid_q;

endmodule

//--- src/mem_clear.sv
`timescale 1ns/1ns

module mem_clear (
  input  logic               clk_i,
  input  logic               reset_l,
  input  logic               clr_gnt_i,
  output logic               clr_we_o,
  output tile_pkg::ev_addr_t clr_addr_o
);

  // sweep runs off the raw reset, so it is done long before the tile wakes
  tile_pkg::clear_state_e state_q;
  tile_pkg::clear_state_e state_d;
  tile_pkg::ev_addr_t     addr_q;
  logic                   last_addr;
  logic                   step;

  assign last_addr = (addr_q == tile_pkg::ev_addr_t'(tile_pkg::EV_DEPTH - 1));

  // only move on when the arbiter took the write
  assign step = clr_we_o & clr_gnt_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      tile_pkg::CLR_RUN: begin
        if (step && last_addr) begin
          state_d = tile_pkg::CLR_DONE;
        end
      end
      default: begin
        // done is terminal until the next reset
        state_d = tile_pkg::CLR_DONE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q <= tile_pkg::CLR_RUN;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (step) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  // zero data is supplied by the arbiter
  assign clr_we_o   = (state_q == tile_pkg::CLR_RUN);
  assign clr_addr_o = addr_q;

endmodule

//--- src/sync_2ff.sv
`timescale 1ns/1ns

module sync_2ff (
  input  logic clk_i,
  input  logic reset_l,
  input  logic d_i,
  output logic q_o
);

  // first stage may go metastable
  logic meta_q;
  // second stage has a full cycle to settle
  logic sync_q;

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      meta_q <= 1'b0;
      sync_q <= 1'b0;
    end else begin
      meta_q <= d_i;
      sync_q <= meta_q;
    end
  end

  assign q_o = sync_q;

endmodule

//--- src/tile_pkg.sv
package tile_pkg;

  ////////////////////
  // sizes
  ////////////////////

  // wake-up counter, top bit sets after 32 cycles
  localparam int WAKE_CNT_W = 6;

  // event ring
  localparam int EV_DEPTH  = 16;
  localparam int EV_ADDR_W = $clog2(EV_DEPTH);

  // irq[1:0], ipi, timer, debug
  localparam int NUM_SRC = 5;

  // record layout: {src_id, tstamp}
  localparam int SRC_ID_W  = 3;
  localparam int TSTAMP_W  = 13;
  localparam int EV_DATA_W = SRC_ID_W + TSTAMP_W;

  ////////////////////
  // types
  ////////////////////

  typedef logic [EV_ADDR_W-1:0] ev_addr_t;
  typedef logic [EV_DATA_W-1:0] ev_data_t;
  typedef logic [SRC_ID_W-1:0]  src_id_t;
  typedef logic [TSTAMP_W-1:0]  tstamp_t;
  typedef logic [NUM_SRC-1:0]   src_vec_t;

  typedef enum logic {CLR_RUN, CLR_DONE} clear_state_e;

endpackage

//--- src/tile_wrap.sv
`timescale 1ns/1ns

module tile_wrap (
  input  logic               clk_i,
  input  logic               reset_l,
  input  logic [1:0]         irq_i,
  input  logic               ipi_i,
  input  logic               time_irq_i,
  input  logic               debug_req_i,
  input  logic               host_req_i,
  input  tile_pkg::ev_addr_t host_addr_i,
  output logic               spc_grst_l,
  output logic               host_rvalid_o,
  output tile_pkg::ev_data_t host_rdata_o,
  output tile_pkg::ev_addr_t ev_wr_ptr_o
);

  tile_pkg::src_vec_t src_raw;
  tile_pkg::src_vec_t src_sync;

  logic               clr_we;
  logic               clr_gnt;
  tile_pkg::ev_addr_t clr_addr;
  logic               log_we;
  logic               log_gnt;
  tile_pkg::ev_addr_t log_addr;
  tile_pkg::ev_data_t log_data;
  logic               mem_we;
  logic               mem_re;
  tile_pkg::ev_addr_t mem_addr;
  tile_pkg::ev_data_t mem_wdata;

  ////////////////////
  // reset
  ////////////////////

  wake_reset_gen u_wake (
    .clk_i      (clk_i),
    .reset_l    (reset_l),
    .spc_grst_l (spc_grst_l)
  );

  ////////////////////
  // event inputs
  ////////////////////

  // ids 0..4 = irq0, irq1, ipi, timer, debug
  assign src_raw = {debug_req_i, time_irq_i, ipi_i, irq_i};

  for (genvar k = 0; k < tile_pkg::NUM_SRC; k++) begin : g_src_sync
    sync_2ff u_sync (
      .clk_i   (clk_i),
      .reset_l (reset_l),
      .d_i     (src_raw[k]),
      .q_o     (src_sync[k])
    );
  end

  ////////////////////
  // memory peers
  ////////////////////

  mem_clear u_clear (
    .clk_i      (clk_i),
    .reset_l    (reset_l),
    .clr_gnt_i  (clr_gnt),
    .clr_we_o   (clr_we),
    .clr_addr_o (clr_addr)
  );

  // logger waits for the gated tile reset
  event_logger u_logger (
    .clk_i      (clk_i),
    .rst_n_i    (spc_grst_l),
    .src_i      (src_sync),
    .log_gnt_i  (log_gnt),
    .log_we_o   (log_we),
    .log_addr_o (log_addr),
    .log_data_o (log_data),
    .wr_ptr_o   (ev_wr_ptr_o)
  );

  mem_arbiter u_arb (
    .clk_i         (clk_i),
    .reset_l       (reset_l),
    .clr_we_i      (clr_we),
    .clr_addr_i    (clr_addr),
    .log_we_i      (log_we),
    .log_addr_i    (log_addr),
    .log_data_i    (log_data),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .clr_gnt_o     (clr_gnt),
    .log_gnt_o     (log_gnt),
    .mem_we_o      (mem_we),
    .mem_re_o      (mem_re),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .host_rvalid_o (host_rvalid_o)
  );

  event_sram u_sram (
    .clk_i   (clk_i),
    .we_i    (mem_we),
    .re_i    (mem_re),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (host_rdata_o)
  );

endmodule

//--- src/wake_reset_gen.sv
`timescale 1ns/1ns

module wake_reset_gen (
  input  logic clk_i,
  input  logic reset_l,
  output logic spc_grst_l
);

  ////////////////////
  // wake-up counter
  ////////////////////

  // gives the event memory time to be swept before the tile runs
  logic [tile_pkg::WAKE_CNT_W-1:0] wake_cnt_q;
  logic                            wake_done;
  logic                            rst_gated_l;

  // top bit is the done flag, counter parks there
  assign wake_done = wake_cnt_q[tile_pkg::WAKE_CNT_W-1];

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt_q <= '0;
    end else if (!wake_done) begin
      wake_cnt_q <= wake_cnt_q + 1'b1;
    end
  end

  // raw reset still asserts at once
  assign rst_gated_l = wake_done & reset_l;

  ////////////////////
  // output sync
  ////////////////////

  // release edge gets two more flops, assertion stays async
  sync_2ff u_rst_sync (
    .clk_i   (clk_i),
    .reset_l (reset_l),
    .d_i     (rst_gated_l),
    .q_o     (spc_grst_l)
  );

endmodule

//--- verif/tile_wrap_checker.sv
`timescale 1ns/1ns

module tile_wrap_checker (
  input logic               clk_i,
  input logic               reset_l,
  input logic               spc_grst_l,
  input logic               host_rvalid_o,
  input tile_pkg::ev_addr_t ev_wr_ptr_o,
  input logic               mem_re,
  input logic               mem_we,
  input logic               clr_we,
  input logic               log_we
);

  // assertion failures seen so far
  int fail_cnt = 0;

  // counts edges since reset_l went high and parks at the top
  logic [6:0] rel_cnt;

  always @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      rel_cnt <= '0;
    end else if (rel_cnt != 7'd127) begin
      rel_cnt <= rel_cnt + 7'd1;
    end
  end

  ////////////////////
  // wake-up reset
  ////////////////////

  // 32 edges for the counter and 2 for the sync
  a_grst_low: assert property (@(posedge clk_i) (rel_cnt < 7'd34) |-> !spc_grst_l)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("tile reset released too early");
    end

  a_grst_high: assert property (@(posedge clk_i) (rel_cnt >= 7'd34) |-> spc_grst_l)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("tile reset not released or dropped");
    end

  ////////////////////
  // host read valid
  ////////////////////

  a_rvalid_single: assert property (@(posedge clk_i) disable iff (!reset_l)
    host_rvalid_o |=> !host_rvalid_o)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("read valid high two cycles in a row");
    end

  a_read_gives_valid: assert property (@(posedge clk_i) disable iff (!reset_l)
    mem_re |=> host_rvalid_o)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("granted read gave no valid pulse");
    end

  a_valid_from_read: assert property (@(posedge clk_i) disable iff (!reset_l)
    host_rvalid_o |-> $past(mem_re))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("valid pulse without a granted read");
    end

  ////////////////////
  // ring pointer
  ////////////////////

  // holds or steps by one with the 4-bit sum wrapping
  a_ptr_step: assert property (@(posedge clk_i) disable iff (!spc_grst_l)
    (ev_wr_ptr_o == $past(ev_wr_ptr_o)) ||
    (ev_wr_ptr_o == $past(ev_wr_ptr_o) + tile_pkg::ev_addr_t'(1)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("write pointer jumped");
    end

  ////////////////////
  // write gating
  ////////////////////

  a_we_gated: assert property (@(posedge clk_i) disable iff (!reset_l)
    mem_we |-> (clr_we || spc_grst_l))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("memory write while tile in reset");
    end

  a_log_quiet: assert property (@(posedge clk_i) disable iff (!reset_l)
    !spc_grst_l |-> !log_we)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("logger wrote while tile in reset");
    end

  // sweep is over before the tile wakes
  a_clear_early: assert property (@(posedge clk_i) disable iff (!reset_l)
    clr_we |-> !spc_grst_l)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("clear sweep still running after wake");
    end

endmodule

//--- verif/tile_wrap_tb.sv
`timescale 1ns/1ns

module tile_wrap_tb;

  localparam int          TIMEOUT_CYC = 4000;
  localparam logic [31:0] SEED        = 32'hdb42_0b12;

  logic               clk_i;
  logic               reset_l;
  tile_pkg::src_vec_t src_drv;
  logic [1:0]         irq_i;
  logic               ipi_i;
  logic               time_irq_i;
  logic               debug_req_i;
  logic               host_req_i;
  tile_pkg::ev_addr_t host_addr_i;
  logic               spc_grst_l;
  logic               host_rvalid_o;
  tile_pkg::ev_data_t host_rdata_o;
  tile_pkg::ev_addr_t ev_wr_ptr_o;

  // model of the event ring
  tile_pkg::src_id_t  exp_src [tile_pkg::EV_DEPTH];
  tile_pkg::ev_addr_t exp_ptr;

  logic [31:0] rnd_state;
  int          err_cnt   = 0;
  int          cycle_cnt = 0;

  // source ids 0..4 = irq0, irq1, ipi, timer, debug
  assign irq_i       = src_drv[1:0];
  assign ipi_i       = src_drv[2];
  assign time_irq_i  = src_drv[3];
  assign debug_req_i = src_drv[4];

  tile_wrap uut (
    .clk_i         (clk_i),
    .reset_l       (reset_l),
    .irq_i         (irq_i),
    .ipi_i         (ipi_i),
    .time_irq_i    (time_irq_i),
    .debug_req_i   (debug_req_i),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .spc_grst_l    (spc_grst_l),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .ev_wr_ptr_o   (ev_wr_ptr_o)
  );

  bind tile_wrap tile_wrap_checker u_chk (
    .clk_i         (clk_i),
    .reset_l       (reset_l),
    .spc_grst_l    (spc_grst_l),
    .host_rvalid_o (host_rvalid_o),
    .ev_wr_ptr_o   (ev_wr_ptr_o),
    .mem_re        (mem_re),
    .mem_we        (mem_we),
    .clr_we        (clr_we),
    .log_we        (log_we)
  );

  always #2 clk_i = ~clk_i;

  // run limit well above the expected length
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_below(input int n);
    rnd_state = xorshift(rnd_state);
    return int'(rnd_state % 32'(n));
  endfunction

  function automatic logic bit_of(input tile_pkg::src_vec_t v, input int k);
    tile_pkg::src_vec_t t;
    t = v >> k;
    return t[0];
  endfunction

  // record is {src_id, tstamp}
  function automatic int rec_src(input tile_pkg::ev_data_t r);
    return int'(r[tile_pkg::EV_DATA_W-1 -: tile_pkg::SRC_ID_W]);
  endfunction

  function automatic int rec_time(input tile_pkg::ev_data_t r);
    return int'(r[tile_pkg::TSTAMP_W-1:0]);
  endfunction

  task automatic check_equal(input int got, input int exp, input string what);
    assert (got == exp) else begin
      err_cnt++;
      $display("CHECK FAILED @%0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    assert (ok) else begin
      err_cnt++;
      $display("CHECK FAILED @%0t: %s", $time, what);
    end
  endtask

  task automatic model_push(input int id);
    exp_src[exp_ptr] = tile_pkg::src_id_t'(id);
    exp_ptr = exp_ptr + tile_pkg::ev_addr_t'(1);
  endtask

  // assert reset for five cycles and wait for the tile to wake
  task automatic apply_reset();
    reset_l = 1'b0;
    repeat (5) @(negedge clk_i);
    reset_l = 1'b1;
    while (!spc_grst_l) begin
      @(negedge clk_i);
    end
  endtask

  // hold the request level until the valid pulse
  task automatic read_mem(input tile_pkg::ev_addr_t addr, output tile_pkg::ev_data_t data,
                          output int waited);
    host_addr_i = addr;
    host_req_i  = 1'b1;
    waited      = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!host_rvalid_o);
    data       = host_rdata_o;
    host_req_i = 1'b0;
  endtask

  task automatic wait_ptr();
    while (ev_wr_ptr_o != exp_ptr) begin
      @(negedge clk_i);
    end
  endtask

  task automatic pulse_source(input int id, input int gap);
    src_drv = src_drv | (tile_pkg::src_vec_t'(1) << id);
    repeat (gap) @(negedge clk_i);
    src_drv = src_drv & ~(tile_pkg::src_vec_t'(1) << id);
    repeat (gap) @(negedge clk_i);
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    tile_pkg::ev_data_t rec;
    tile_pkg::ev_addr_t base;
    tile_pkg::ev_addr_t old_ptr;
    tile_pkg::src_vec_t mask;
    int                 waited;
    int                 id;
    int                 n_set;
    int                 fill_cnt;
    int                 prev_time;
    int                 chk_fails;

    clk_i       = 1'b0;
    reset_l     = 1'b0;
    src_drv     = '0;
    host_req_i  = 1'b0;
    host_addr_i = '0;
    exp_ptr     = '0;
    rnd_state   = SEED;
    for (int i = 0; i < tile_pkg::EV_DEPTH; i++) begin
      exp_src[i] = '0;
    end

    apply_reset();

    // single edges with the level held well past detection
    repeat (3) begin
      id      = rand_below(tile_pkg::NUM_SRC);
      old_ptr = exp_ptr;
      model_push(id);
      src_drv = src_drv | (tile_pkg::src_vec_t'(1) << id);
      wait_ptr();
      repeat (10) @(negedge clk_i);
      check_equal(int'(ev_wr_ptr_o), int'(exp_ptr), "pointer after held level");
      read_mem(old_ptr, rec, waited);
      check_equal(rec_src(rec), id, "single event source id");
      src_drv = '0;
      repeat (6 + rand_below(4)) @(negedge clk_i);
    end

    // same-cycle edges with bits 0 and 4 always set
    mask  = tile_pkg::src_vec_t'(rand_below(32)) | tile_pkg::src_vec_t'(17);
    base  = exp_ptr;
    n_set = 0;
    for (int k = 0; k < tile_pkg::NUM_SRC; k++) begin
      if (bit_of(mask, k)) begin
        model_push(k);
        n_set++;
      end
    end
    src_drv = mask;
    wait_ptr();
    repeat (4) @(negedge clk_i);
    check_equal(int'(ev_wr_ptr_o), int'(exp_ptr), "pointer after multi edge");
    prev_time = 0;
    for (int j = 0; j < n_set; j++) begin
      read_mem(base + tile_pkg::ev_addr_t'(j), rec, waited);
      check_equal(rec_src(rec), int'(exp_src[base + tile_pkg::ev_addr_t'(j)]),
                  $sformatf("multi edge record %0d", j));
      if (j > 0) begin
        check_cond(rec_time(rec) >= prev_time, "timestamps out of order");
      end
      prev_time = rec_time(rec);
    end
    src_drv = '0;
    repeat (8) @(negedge clk_i);

    // wrap the ring so it ends with the pointer at 4
    fill_cnt = 16 + int'(tile_pkg::ev_addr_t'(4) - exp_ptr);
    if (fill_cnt < 20) begin
      fill_cnt += 16;
    end
    for (int n = 0; n < fill_cnt; n++) begin
      id = rand_below(tile_pkg::NUM_SRC);
      model_push(id);
      pulse_source(id, 6 + rand_below(4));
    end
    wait_ptr();
    check_equal(int'(ev_wr_ptr_o), 4, "pointer after wrap");
    for (int a = 0; a < tile_pkg::EV_DEPTH; a++) begin
      read_mem(tile_pkg::ev_addr_t'(a), rec, waited);
      check_equal(rec_src(rec), int'(exp_src[a]), $sformatf("ring word %0d after wrap", a));
    end

    // host read stalled behind a five-write burst
    base = exp_ptr;
    for (int k = 0; k < tile_pkg::NUM_SRC; k++) begin
      model_push(k);
    end
    src_drv = '1;
    while (ev_wr_ptr_o == base) begin
      @(negedge clk_i);
    end
    read_mem(base + tile_pkg::ev_addr_t'(4), rec, waited);
    check_equal(rec_src(rec), 4, "read behind burst");
    check_cond(waited >= 2, "read was not held back by the burst");
    repeat (3) begin
      @(negedge clk_i);
      check_cond(!host_rvalid_o, "extra valid pulse after read");
    end
    wait_ptr();
    check_equal(int'(ev_wr_ptr_o), int'(exp_ptr), "pointer after burst");
    src_drv = '0;
    repeat (6) @(negedge clk_i);

    // every ring word holds a record here and the sweep must zero them all
    apply_reset();
    exp_ptr = '0;
    check_equal(int'(ev_wr_ptr_o), int'(exp_ptr), "pointer after second reset");
    for (int a = 0; a < tile_pkg::EV_DEPTH; a++) begin
      read_mem(tile_pkg::ev_addr_t'(a), rec, waited);
      check_equal(int'(rec), 0, $sformatf("cleared word at %0d", a));
    end

    ////////////////////
    // report
    ////////////////////

    chk_fails = uut.u_chk.fail_cnt;
    $display("errors: checks %0d, assertions %0d", err_cnt, chk_fails);
    if (err_cnt == 0 && chk_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
src/tile_pkg.sv
src/sync_2ff.sv
src/wake_reset_gen.sv
src/mem_clear.sv
src/event_logger.sv
src/mem_arbiter.sv
src/event_sram.sv
src/tile_wrap.sv
verif/tile_wrap_checker.sv
verif/tile_wrap_tb.sv
